//--- Makefile
# Verilator simulation of the multiplier array testbench

VERILATOR ?= verilator
TOP       ?= tbMultiplierArray
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Pass only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tbMultiplierArray.sv
`timescale 1ns/1ps
`default_nettype none

module tbMultiplierArray;

    import mulDataPkg::*;

    localparam int NumLanes = 4;
    localparam int ExpectedLatency = 12;                 // Dispatcher 1, lane 10, collector 1
    localparam int NumCorners = 6;
    localparam int NumRandom = 300;
    localparam int NumOrdered = 8;
    localparam int NumDropped = 20;                      // Lost to the mid-stream reset
    localparam int NumRestart = 40;
    localparam int OperandCount = NumCorners + NumRandom + NumOrdered + NumDropped + NumRestart;
    localparam int CycleLimit = OperandCount * ExpectedLatency + 200;

    typedef struct packed {
        mulOperands_t ops;
        int           issueCycle;
    } issued_t;

    logic         CLK;
    logic         RESET;
    logic         inStrobe;
    mulOperands_t operands;
    logic         busy;
    logic         outStrobe;
    mulProduct_t  product;

    issued_t issuedQueue [$];                            // Accepted but not yet seen at the output
    int      cycle = 0;
    int      seed;
    string   testName;

    multiplierArray #(.NUM_LANES(NumLanes)) dut (
        .CLK       (CLK),
        .RESET     (RESET),
        .inStrobe  (inStrobe),
        .operands  (operands),
        .busy      (busy),
        .outStrobe (outStrobe),
        .product   (product)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    task automatic failRun();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at cycle %0d", cycle);
    endtask

    always @(posedge CLK) begin
        cycle <= cycle + 1;
        if (cycle >= CycleLimit) begin
            $display("Timeout, the run did not finish within %0d cycles", CycleLimit);
            failRun();
        end
    end

    // Signed 8 x 8 product is exact in 16 bits
    function automatic mulProduct_t expectedProduct(input mulOperands_t ops);
        mulProduct_t result;
        int          full;
        full = int'($signed(ops.multiplicand)) * int'($signed(ops.multiplier));
        result.value = 16'(full);
        return result;
    endfunction

    task automatic checkProduct(input string name, input mulProduct_t expected,
                                input mulProduct_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %0d actual %0d", name, expected.value, actual.value);
            failRun();
        end
    endtask

    task automatic checkLatency(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("Error: %s latency expected %0d actual %0d", name, expected, actual);
            failRun();
        end
    endtask

    task automatic verifyLevel(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error: %s expected %b actual %b", name, expected, actual);
            failRun();
        end
    endtask

    // Both cycle stamps sit one edge before their sampling edge and subtract cleanly
    always @(negedge CLK) begin : compareOutputs
        issued_t head;
        if (!RESET && outStrobe) begin
            if (issuedQueue.size() == 0) begin
                $display("outStrobe pulsed in %s with no operation outstanding", testName);
                failRun();
            end else begin
                head = issuedQueue.pop_front();
                checkProduct(testName, expectedProduct(head.ops), product);
                checkLatency(testName, ExpectedLatency, cycle - head.issueCycle);
            end
        end
    end

    // Strobes on the first cycle where busy is low
    task automatic issueOperands(input mulOperands_t ops);
        bit accepted;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge CLK);
            #1;
            if (busy) begin
                inStrobe = 1'b0;
            end else begin
                inStrobe = 1'b1;
                operands = ops;
                issuedQueue.push_back(issued_t'{ops: ops, issueCycle: cycle});
                accepted = 1'b1;
            end
        end
    endtask

    task automatic idleInputs();
        @(posedge CLK);
        #1;
        inStrobe = 1'b0;
    endtask

    task automatic waitDrained();
        while (issuedQueue.size() != 0) begin
            @(posedge CLK);
        end
    endtask

    // Reset held for two edges with outputs checked in reset and after release
    task automatic applyReset();
        RESET = 1'b1;
        inStrobe = 1'b0;
        issuedQueue.delete();                            // In-flight work is dropped
        @(posedge CLK);
        @(negedge CLK);
        verifyLevel("busy in reset", 1'b0, busy);
        verifyLevel("outStrobe in reset", 1'b0, outStrobe);
        @(posedge CLK);
        #1;
        RESET = 1'b0;
        @(negedge CLK);
        verifyLevel("busy after reset", 1'b0, busy);
        verifyLevel("outStrobe after reset", 1'b0, outStrobe);
    endtask

    task automatic cornerCase(input logic signed [OPERAND_WIDTH-1:0] a,
                              input logic signed [OPERAND_WIDTH-1:0] b);
        mulOperands_t ops;
        ops.multiplicand = a;
        ops.multiplier = b;
        issueOperands(ops);
        idleInputs();
        waitDrained();
        @(negedge CLK);
        verifyLevel("outStrobe pulse width", 1'b0, outStrobe);   // Single-cycle pulse
    endtask

    task automatic randomStream(input int count);
        mulOperands_t ops;
        for (int i = 0; i < count; i++) begin
            ops = mulOperands_t'(16'($random(seed)));
            issueOperands(ops);
        end
    endtask

    // Distinct products back to back make any reordering visible
    task automatic orderedBurst();
        mulOperands_t ops;
        for (int i = 0; i < NumOrdered; i++) begin
            ops.multiplicand = 8'(i * 29 - 101);
            ops.multiplier = 8'(113 - i * 37);
            issueOperands(ops);
        end
    endtask

    initial begin
        seed = 32'h67c27150;
        RESET = 1'b1;
        inStrobe = 1'b0;
        operands = '0;
        testName = "reset";
        applyReset();

        testName = "corner";
        cornerCase(8'sh00, 8'shB3);                      // 0 x -77
        cornerCase(8'sh7F, 8'sh7F);
        cornerCase(8'sh80, 8'sh80);                      // 16384
        cornerCase(8'sh80, 8'sh7F);
        cornerCase(8'shFF, 8'shFF);
        cornerCase(8'sh01, 8'shFF);

        testName = "random";
        randomStream(NumRandom);
        idleInputs();
        waitDrained();

        testName = "ordering";
        orderedBurst();
        idleInputs();
        waitDrained();

        testName = "resetMidStream";
        randomStream(NumDropped);
        applyReset();

        testName = "restart";
        randomStream(NumRestart);
        idleInputs();
        waitDrained();

        repeat (2 * ExpectedLatency) @(posedge CLK);    // No stray strobes afterwards
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/karatsubaDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module karatsubaDatapath (
    input  wire                           CLK,
    input  wire                           RESET,
    input  wire mulCtrlPkg::step_t        step,
    input  wire mulDataPkg::mulOperands_t operands,
    output mulDataPkg::romAddr_t          romAddr,
    input  wire mulDataPkg::romData_t     romData,
    output mulDataPkg::mulProduct_t       product
);

    import mulDataPkg::*;
    import mulCtrlPkg::*;

    logic [OPERAND_WIDTH-1:0] magA;                      // Unsigned, 128 fits
    logic [OPERAND_WIDTH-1:0] magB;
    logic                     negative;                  // Operand signs differ
    logic [SUM_WIDTH-1:0]     sumA;
    logic [SUM_WIDTH-1:0]     sumB;
    romData_t                 lowProd;
    romData_t                 highProd;
    romData_t                 midProd;
    romData_t                 crossTerm;
    logic [PRODUCT_WIDTH-1:0] magProduct;

    function automatic logic [OPERAND_WIDTH-1:0] magnitude(
        input logic signed [OPERAND_WIDTH-1:0] value
    );
        logic [OPERAND_WIDTH-1:0] result;
        result = value[OPERAND_WIDTH-1] ? OPERAND_WIDTH'(-value) : OPERAND_WIDTH'(value);
        return result;
    endfunction

    // Cross term of the half products, never negative
    assign crossTerm = midProd - lowProd - highProd;

    always_ff @(posedge CLK) begin
        unique case (step)
            LoadMag: begin
                magA <= magnitude(operands.multiplicand);
                magB <= magnitude(operands.multiplier);
                negative <= operands.multiplicand[OPERAND_WIDTH-1]
                            ^ operands.multiplier[OPERAND_WIDTH-1];
            end
            LoadSums: begin
                sumA <= SUM_WIDTH'(magA[OPERAND_WIDTH-1:HALF_WIDTH])
                        + SUM_WIDTH'(magA[HALF_WIDTH-1:0]);
                sumB <= SUM_WIDTH'(magB[OPERAND_WIDTH-1:HALF_WIDTH])
                        + SUM_WIDTH'(magB[HALF_WIDTH-1:0]);
            end
            AddrLow: begin
                romAddr.lhs <= SUM_WIDTH'(magA[HALF_WIDTH-1:0]);
                romAddr.rhs <= SUM_WIDTH'(magB[HALF_WIDTH-1:0]);
            end
            CapLow: lowProd <= romData;
            AddrHigh: begin
                romAddr.lhs <= SUM_WIDTH'(magA[OPERAND_WIDTH-1:HALF_WIDTH]);
                romAddr.rhs <= SUM_WIDTH'(magB[OPERAND_WIDTH-1:HALF_WIDTH]);
            end
            CapHigh: highProd <= romData;
            AddrMid: begin
                romAddr.lhs <= sumA;
                romAddr.rhs <= sumB;
            end
            CapMid: midProd <= romData;
            Combine: begin
                magProduct <= (PRODUCT_WIDTH'(highProd) << OPERAND_WIDTH)
                              + (PRODUCT_WIDTH'(crossTerm) << HALF_WIDTH)
                              + PRODUCT_WIDTH'(lowProd);
            end
            SignFix: product.value <= negative ? -magProduct : magProduct;
            default: ;                                   // Idle holds everything
        endcase
    end

    // Karatsuba identity, the mid product covers both outer products
    midCoversOuter: assert property (@(posedge CLK) disable iff (RESET)
        (step == Combine) |-> ((2*SUM_WIDTH+1)'(midProd)
                               >= (2*SUM_WIDTH+1)'(lowProd) + (2*SUM_WIDTH+1)'(highProd)));

endmodule

`default_nettype wire

//--- source/karatsubaSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module karatsubaSequencer (
    input  wire                CLK,
    input  wire                RESET,
    input  wire                start,
    output mulCtrlPkg::step_t  step,
    output logic               busy,
    output logic               done
);

    import mulCtrlPkg::*;

    step_t state;
    step_t nextState;

    // LoadMag is issued on the start cycle itself, while the dispatcher
    // still holds this lane's operands, so the register skips it
    always_comb begin
        unique case (state)
            Idle:     nextState = start ? LoadSums : Idle;
            LoadMag:  nextState = LoadSums;
            LoadSums: nextState = AddrLow;
            AddrLow:  nextState = CapLow;
            CapLow:   nextState = AddrHigh;
            AddrHigh: nextState = CapHigh;
            CapHigh:  nextState = AddrMid;
            AddrMid:  nextState = CapMid;
            CapMid:   nextState = Combine;
            Combine:  nextState = SignFix;
            default:  nextState = Idle;                  // SignFix ends the run
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state <= Idle;
            done <= 1'b0;
        end else begin
            state <= nextState;
            done <= (state == SignFix);                  // Product valid with this pulse
        end
    end

    assign step = (state == Idle && start) ? LoadMag : state;
    assign busy = (state != Idle);

    noStartWhileBusy: assert property (@(posedge CLK) disable iff (RESET)
        start |-> !busy);

    fixedLatency: assert property (@(posedge CLK) disable iff (RESET)
        start |-> ##LANE_LATENCY done);

endmodule

`default_nettype wire

//--- source/mulCtrlPkg.sv
`default_nettype none

// Control encodings of one multiplier lane
package mulCtrlPkg;

    // One step per cycle, in this order
    typedef enum logic [3:0] {
        Idle     = 4'd0,
        LoadMag  = 4'd1,                                // Sign split and magnitudes
        LoadSums = 4'd2,                                // Half-sums for the mid product
        AddrLow  = 4'd3,
        CapLow   = 4'd4,
        AddrHigh = 4'd5,
        CapHigh  = 4'd6,
        AddrMid  = 4'd7,
        CapMid   = 4'd8,
        Combine  = 4'd9,                                // Shift and add of the partials
        SignFix  = 4'd10
    } step_t;

    // Cycles from the sampled start to the sampled done pulse
    localparam int LANE_LATENCY = 10;

endpackage

`default_nettype wire

//--- source/mulDataPkg.sv
`default_nettype none

// Data formats shared by the multiplier lanes and the array top level
package mulDataPkg;

    localparam int OPERAND_WIDTH = 8;
    localparam int PRODUCT_WIDTH = 16;
    localparam int HALF_WIDTH = 4;                      // Karatsuba split point
    localparam int SUM_WIDTH = 5;                       // Half-sum needs one carry bit

    typedef struct packed {
        logic signed [OPERAND_WIDTH-1:0] multiplicand;
        logic signed [OPERAND_WIDTH-1:0] multiplier;
    } mulOperands_t;

    typedef struct packed {
        logic signed [PRODUCT_WIDTH-1:0] value;
    } mulProduct_t;

    // Lookup address, one 5-bit factor per field
    typedef struct packed {
        logic [SUM_WIDTH-1:0] lhs;
        logic [SUM_WIDTH-1:0] rhs;
    } romAddr_t;

    typedef logic [2*SUM_WIDTH-1:0] romData_t;          // Max entry 31 x 31 = 961

endpackage

`default_nettype wire

//--- source/multiplierArray.sv
`timescale 1ns/1ps
`default_nettype none

module multiplierArray #(
    parameter int NUM_LANES = 4
) (
    input  wire                           CLK,
    input  wire                           RESET,
    input  wire                           inStrobe,
    input  wire mulDataPkg::mulOperands_t operands,
    output logic                          busy,
    output logic                          outStrobe,
    output mulDataPkg::mulProduct_t       product
);

    import mulDataPkg::*;

    logic [NUM_LANES-1:0] laneStart;
    logic [NUM_LANES-1:0] laneBusy;
    logic [NUM_LANES-1:0] laneDone;
    mulOperands_t         laneOperands;
    mulProduct_t          laneProduct [NUM_LANES];

    operandDispatcher #(.NUM_LANES(NUM_LANES)) dispatcher (
        .CLK          (CLK),
        .RESET        (RESET),
        .inStrobe     (inStrobe),
        .operands     (operands),
        .laneBusy     (laneBusy),
        .laneStart    (laneStart),
        .laneOperands (laneOperands),
        .busy         (busy)
    );

    // Identical lanes, 10 cycles each, so results stay in issue order
    genvar lane;
    generate
        for (lane = 0; lane < NUM_LANES; lane++) begin : genLane
            multiplierLane laneInst (
                .CLK      (CLK),
                .RESET    (RESET),
                .start    (laneStart[lane]),
                .operands (laneOperands),
                .busy     (laneBusy[lane]),
                .done     (laneDone[lane]),
                .product  (laneProduct[lane])
            );
        end
    endgenerate

    resultCollector #(.NUM_LANES(NUM_LANES)) collector (
        .CLK         (CLK),
        .RESET       (RESET),
        .laneDone    (laneDone),
        .laneProduct (laneProduct),
        .outStrobe   (outStrobe),
        .product     (product)
    );

endmodule

`default_nettype wire

//--- source/multiplierLane.sv
`timescale 1ns/1ps
`default_nettype none

module multiplierLane (
    input  wire                           CLK,
    input  wire                           RESET,
    input  wire                           start,
    input  wire mulDataPkg::mulOperands_t operands,
    output logic                          busy,
    output logic                          done,
    output mulDataPkg::mulProduct_t       product
);

    import mulDataPkg::*;
    import mulCtrlPkg::*;

    step_t    step;
    romAddr_t romAddr;
    romData_t romData;

    karatsubaSequencer sequencer (
        .CLK   (CLK),
        .RESET (RESET),
        .start (start),
        .step  (step),
        .busy  (busy),
        .done  (done)
    );

    karatsubaDatapath datapath (
        .CLK      (CLK),
        .RESET    (RESET),
        .step     (step),
        .operands (operands),
        .romAddr  (romAddr),
        .romData  (romData),
        .product  (product)
    );

    productRom rom (
        .addr (romAddr),
        .data (romData)
    );

endmodule

`default_nettype wire

//--- source/operandDispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module operandDispatcher #(
    parameter int NUM_LANES = 4
) (
    input  wire                           CLK,
    input  wire                           RESET,
    input  wire                           inStrobe,
    input  wire mulDataPkg::mulOperands_t operands,
    input  wire [NUM_LANES-1:0]           laneBusy,
    output logic [NUM_LANES-1:0]          laneStart,
    output mulDataPkg::mulOperands_t      laneOperands,
    output logic                          busy
);

    localparam int PtrWidth = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [PtrWidth-1:0] pointer;                        // Lane for the next operands

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pointer <= '0;
            laneStart <= '0;
        end else begin
            laneStart <= '0;
            if (inStrobe) begin
                laneStart[pointer] <= 1'b1;
                pointer <= (pointer == PtrWidth'(NUM_LANES - 1)) ? '0 : pointer + 1'b1;
            end
        end
    end

    // Shared bus, the started lane latches it on its start cycle
    always_ff @(posedge CLK) begin
        if (inStrobe) laneOperands <= operands;
    end

    // A start still in flight counts as busy, matters only for a single lane
    assign busy = laneBusy[pointer] | laneStart[pointer];

    noStrobeWhileBusy: assert property (@(posedge CLK) disable iff (RESET)
        inStrobe |-> !busy);

endmodule

`default_nettype wire

//--- source/productRom.sv
`timescale 1ns/1ps
`default_nettype none

module productRom (
    input  wire mulDataPkg::romAddr_t addr,
    output mulDataPkg::romData_t      data
);

    import mulDataPkg::*;

    localparam int unsigned FieldSpan = 1 << SUM_WIDTH;
    localparam int unsigned TableDepth = FieldSpan * FieldSpan;

    romData_t productTable [TableDepth];
    logic [2*SUM_WIDTH-1:0] tableIndex;

    // Table is filled at elaboration, entry = upper field times lower field
    genvar idx;
    generate
        for (idx = 0; idx < TableDepth; idx++) begin : genEntry
            localparam int unsigned Lhs = idx / FieldSpan;
            localparam int unsigned Rhs = idx % FieldSpan;
            localparam int unsigned Prod = Lhs * Rhs;

            assign productTable[idx] = romData_t'(Prod);
        end
    endgenerate

    assign tableIndex = {addr.lhs, addr.rhs};            // Same layout as the struct
    assign data = productTable[tableIndex];

endmodule

`default_nettype wire

//--- source/resultCollector.sv
`timescale 1ns/1ps
`default_nettype none

module resultCollector #(
    parameter int NUM_LANES = 4
) (
    input  wire                          CLK,
    input  wire                          RESET,
    input  wire [NUM_LANES-1:0]          laneDone,
    input  wire mulDataPkg::mulProduct_t laneProduct [NUM_LANES],
    output logic                         outStrobe,
    output mulDataPkg::mulProduct_t      product
);

    localparam int PtrWidth = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [PtrWidth-1:0]  pointer;                       // Lane expected next
    logic [NUM_LANES-1:0] pending;                       // Done seen out of turn
    logic                 take;
    logic [NUM_LANES-1:0] takeMask;

    assign take = laneDone[pointer] | pending[pointer];
    assign takeMask = take ? (NUM_LANES'(1) << pointer) : '0;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pointer <= '0;
            pending <= '0;
            outStrobe <= 1'b0;
        end else begin
            pending <= (pending | laneDone) & ~takeMask;
            outStrobe <= take;
            if (take) begin
                pointer <= (pointer == PtrWidth'(NUM_LANES - 1)) ? '0 : pointer + 1'b1;
            end
        end
    end

    // Lane keeps its product until its next run reaches SignFix
    always_ff @(posedge CLK) begin
        if (take) product <= laneProduct[pointer];
    end

    // A second done before the first is drained would lose a product
    noDoneOverPending: assert property (@(posedge CLK) disable iff (RESET)
        (laneDone & pending) == '0);

endmodule

`default_nettype wire

//--- tb.f
source/mulDataPkg.sv
source/mulCtrlPkg.sv
source/productRom.sv
source/karatsubaDatapath.sv
source/karatsubaSequencer.sv
source/multiplierLane.sv
source/operandDispatcher.sv
source/resultCollector.sv
source/multiplierArray.sv
sim/tbMultiplierArray.sv
